// ==== build.f ====
design/tex_cache_pkg.sv
design/tex_addr_decode.sv
design/tex_tag_table.sv
design/tex_miss_fill.sv
design/tex_cache_mem.sv
design/tex_cache_top.sv
test/tex_mem_model.sv
test/tb_tex_cache.sv

// ==== Bender.yml ====
package:
  name: tex_cache

sources:
  - design/tex_cache_pkg.sv
  - design/tex_addr_decode.sv
  - design/tex_tag_table.sv
  - design/tex_miss_fill.sv
  - design/tex_cache_mem.sv
  - design/tex_cache_top.sv
  - target: test
    files:
      - test/tex_mem_model.sv
      - test/tb_tex_cache.sv

// ==== test/tb_tex_cache.sv ====
`timescale 1ns/1ps

module tb_tex_cache;
    import tex_cache_pkg::*;

    localparam int clk_period      = 40;
    localparam int reset_cycles    = 10;
    // upper bound on the requests issued by all phases
    localparam int n_requests      = 128;
    localparam int watchdog_cycles = n_requests * 60 + table_size + reset_cycles;

    logic                   clk;
    logic                   reset;
    logic                   clear_start;
    logic                   clear_busy;
    tex_req_t               s_ar;
    logic                   s_arvalid;
    logic                   s_arready;
    logic [pixel_width-1:0] s_rdata;
    logic                   s_rvalid;
    logic                   s_rready;
    logic [addr_width-1:0]  m_araddrx;
    logic [addr_width-1:0]  m_araddry;
    logic                   m_arvalid;
    logic                   m_arready;
    logic [pixel_width-1:0] m_rdata;
    logic                   m_rlast;
    logic                   m_rvalid;
    logic                   m_rready;
    logic                   status_hit;
    logic                   status_miss;
    logic                   status_access;

    logic                   rready_random = 1'b0;
    int                     mismatch_count = 0;
    int                     protocol_count = 0;
    int                     pixels_seen = 0;

    // shadow tag table and expected responses
    logic [tag_width-1:0]   shadow_tag [table_size];
    logic [table_size-1:0]  shadow_valid;
    logic [pixel_width-1:0] pix_q [$];
    logic                   hit_q [$];
    logic [15:0]            ar_q [$];
    logic                   pix_pending;
    logic [pixel_width-1:0] exp_pixel;
    logic                   stat_pending;
    logic                   exp_hit;
    logic                   ar_pending;
    logic [addr_width-1:0]  exp_ax;
    logic [addr_width-1:0]  exp_ay;
    logic                   fill_expected;

    tex_cache_top i_dut (
        .clk           (clk),
        .reset         (reset),
        .clear_start   (clear_start),
        .clear_busy    (clear_busy),
        .s_ar          (s_ar),
        .s_arvalid     (s_arvalid),
        .s_arready     (s_arready),
        .s_rdata       (s_rdata),
        .s_rvalid      (s_rvalid),
        .s_rready      (s_rready),
        .m_araddrx     (m_araddrx),
        .m_araddry     (m_araddry),
        .m_arvalid     (m_arvalid),
        .m_arready     (m_arready),
        .m_rdata       (m_rdata),
        .m_rlast       (m_rlast),
        .m_rvalid      (m_rvalid),
        .m_rready      (m_rready),
        .status_hit    (status_hit),
        .status_miss   (status_miss),
        .status_access (status_access)
    );

    tex_mem_model i_mem (
        .clk     (clk),
        .reset   (reset),
        .araddrx (m_araddrx),
        .araddry (m_araddry),
        .arvalid (m_arvalid),
        .arready (m_arready),
        .rdata   (m_rdata),
        .rlast   (m_rlast),
        .rvalid  (m_rvalid),
        .rready  (m_rready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        s_rready = 1'b1;
        forever begin
            @(negedge clk);
            if (rready_random) begin
                s_rready = ($urandom_range(2, 0) != 0);
            end else begin
                s_rready = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // scoreboard
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        logic [blk_addr_width-1:0] bx;
        logic [blk_addr_width-1:0] by;
        logic [index_width-1:0]    idx;
        logic [tag_width-1:0]      tag;
        logic                      hit;

        if (reset) begin
            shadow_valid = '0;
            fill_expected = 1'b0;
            pix_q.delete();
            hit_q.delete();
            ar_q.delete();
        end else begin
            // clears are only issued with nothing in flight
            if (clear_start && !clear_busy) begin
                shadow_valid = '0;
            end
            if (s_arvalid && s_arready) begin
                bx  = s_ar.x[addr_width-1:blk_size];
                by  = s_ar.y[addr_width-1:blk_size];
                idx = {by[1:0], bx[1:0]};
                tag = {by[5:2], bx[5:2]};
                hit = shadow_valid[idx] && (shadow_tag[idx] == tag);
                pix_q.push_back(pixel_width'(s_ar.x + 16 * s_ar.y + s_ar.y));
                hit_q.push_back(hit);
                if (!hit) begin
                    ar_q.push_back({bx, 2'b00, by, 2'b00});
                    shadow_valid[idx] = 1'b1;
                    shadow_tag[idx]   = tag;
                end
            end
            if (s_rvalid && s_rready && pix_q.size() != 0) begin
                void'(pix_q.pop_front());
                pixels_seen++;
            end
            if ((status_hit || status_miss) && hit_q.size() != 0) begin
                void'(hit_q.pop_front());
            end
            if (m_arvalid && m_arready && ar_q.size() != 0) begin
                void'(ar_q.pop_front());
            end
            // memory data is taken from the request until the last beat
            if (m_arvalid && m_arready) begin
                fill_expected = 1'b1;
            end else if (m_rvalid && m_rlast) begin
                fill_expected = 1'b0;
            end
        end
        pix_pending  = (pix_q.size() != 0);
        exp_pixel    = pix_pending ? pix_q[0] : '0;
        stat_pending = (hit_q.size() != 0);
        exp_hit      = stat_pending ? hit_q[0] : 1'b0;
        ar_pending   = (ar_q.size() != 0);
        exp_ax       = ar_pending ? ar_q[0][15:8] : '0;
        exp_ay       = ar_pending ? ar_q[0][7:0] : '0;
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    pixel_expected: assert property (
        @(posedge clk) disable iff (reset)
        (s_rvalid && s_rready) |-> pix_pending
    ) else begin
        protocol_count++;
        $display("pixel returned with no request outstanding at %0t", $time);
    end

    pixel_value: assert property (
        @(posedge clk) disable iff (reset)
        (s_rvalid && s_rready && pix_pending) |-> (s_rdata == exp_pixel)
    ) else begin
        mismatch_count++;
        $display("MISMATCH s_rdata: got %h, expected %h", $sampled(s_rdata),
                 $sampled(exp_pixel));
    end

    // held under back-pressure
    pixel_held: assert property (
        @(posedge clk) disable iff (reset)
        (s_rvalid && !s_rready) |=> s_rvalid
    ) else begin
        protocol_count++;
        $display("s_rvalid dropped before the pixel was taken at %0t", $time);
    end

    pixel_stable: assert property (
        @(posedge clk) disable iff (reset)
        (s_rvalid && !s_rready) |=> $stable(s_rdata)
    ) else begin
        mismatch_count++;
        $display("MISMATCH s_rdata: got %h, expected %h", $sampled(s_rdata),
                 $past(s_rdata));
    end

    status_expected: assert property (
        @(posedge clk) disable iff (reset)
        (status_hit || status_miss) |-> stat_pending
    ) else begin
        protocol_count++;
        $display("status pulse with no lookup outstanding at %0t", $time);
    end

    status_value: assert property (
        @(posedge clk) disable iff (reset)
        ((status_hit || status_miss) && stat_pending) |->
            (status_hit == exp_hit && status_miss == !exp_hit)
    ) else begin
        mismatch_count++;
        $display("MISMATCH status_hit: got %h, expected %h", $sampled(status_hit),
                 $sampled(exp_hit));
    end

    access_after_miss: assert property (
        @(posedge clk) disable iff (reset)
        status_miss |=> status_access
    ) else begin
        protocol_count++;
        $display("status_access low after a miss at %0t", $time);
    end

    // one memory request per predicted miss
    request_expected: assert property (
        @(posedge clk) disable iff (reset)
        (m_arvalid && m_arready) |-> ar_pending
    ) else begin
        protocol_count++;
        $display("memory request without a predicted miss at %0t", $time);
    end

    request_origin_x: assert property (
        @(posedge clk) disable iff (reset)
        (m_arvalid && m_arready && ar_pending) |-> (m_araddrx == exp_ax)
    ) else begin
        mismatch_count++;
        $display("MISMATCH m_araddrx: got %h, expected %h", $sampled(m_araddrx),
                 $sampled(exp_ax));
    end

    request_origin_y: assert property (
        @(posedge clk) disable iff (reset)
        (m_arvalid && m_arready && ar_pending) |-> (m_araddry == exp_ay)
    ) else begin
        mismatch_count++;
        $display("MISMATCH m_araddry: got %h, expected %h", $sampled(m_araddry),
                 $sampled(exp_ay));
    end

    fill_ready: assert property (
        @(posedge clk) disable iff (reset)
        m_rready == fill_expected
    ) else begin
        mismatch_count++;
        $display("MISMATCH m_rready: got %h, expected %h", $sampled(m_rready),
                 $sampled(fill_expected));
    end

    clear_begins: assert property (
        @(posedge clk) disable iff (reset)
        (clear_start && !clear_busy) |=> clear_busy
    ) else begin
        protocol_count++;
        $display("clear_busy did not rise after clear_start at %0t", $time);
    end

    clear_ends: assert property (
        @(posedge clk) disable iff (reset)
        $rose(clear_busy) |-> ##[1:table_size] !clear_busy
    ) else begin
        protocol_count++;
        $display("clear_busy stayed high longer than %0d cycles", table_size);
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    // leaves s_arvalid high so requests can follow back to back
    task automatic send_req(input logic [addr_width-1:0] x, input logic [addr_width-1:0] y);
        s_ar.x    = x;
        s_ar.y    = y;
        s_arvalid = 1'b1;
        @(posedge clk);
        while (!s_arready) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic wait_drained();
        while (pix_q.size() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatches, %0d other failures, %0d pixels checked",
                 mismatch_count, protocol_count, pixels_seen);
    endtask

    initial begin
        int                    seed_val;
        logic [table_size-1:0] resident;
        logic [tag_width-1:0]  resident_tag [table_size];
        logic [5:0]            bx;
        logic [5:0]            by;

        seed_val    = $urandom(82);
        reset       = 1'b1;
        clear_start = 1'b0;
        s_ar        = '0;
        s_arvalid   = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // a few pixels from each of eight blocks
        for (int b = 0; b < 8; b++) begin
            for (int p = 0; p < 3; p++) begin
                send_req(8'(4 * b + p), 8'(4 * (b % 3) + p));
            end
        end
        s_arvalid = 1'b0;
        wait_drained();

        // blocks (1, 2) and (5, 2) share an index
        for (int i = 0; i < 12; i++) begin
            send_req(8'(((i % 2 == 0) ? 4 : 20) + $urandom_range(3, 0)),
                     8'(8 + $urandom_range(3, 0)));
        end
        s_arvalid = 1'b0;
        wait_drained();

        // clear, then revisit what was resident
        resident = shadow_valid;
        for (int i = 0; i < table_size; i++) begin
            resident_tag[i] = shadow_tag[i];
        end
        clear_start = 1'b1;
        @(negedge clk);
        clear_start = 1'b0;
        do @(negedge clk); while (clear_busy);
        for (int i = 0; i < table_size; i++) begin
            if (resident[i]) begin
                bx = {resident_tag[i][3:0], 2'(i)};
                by = {resident_tag[i][7:4], 2'(i >> 2)};
                send_req({bx, 2'b11}, {by, 2'b01});
            end
        end
        s_arvalid = 1'b0;
        wait_drained();

        // random addresses under random back-pressure
        rready_random = 1'b1;
        for (int i = 0; i < 64; i++) begin
            if (i % 4 == 0) begin
                send_req(8'($urandom_range(255, 0)), 8'($urandom_range(255, 0)));
            end else begin
                send_req(8'($urandom_range(31, 0)), 8'($urandom_range(31, 0)));
            end
            if ($urandom_range(3, 0) == 0) begin
                s_arvalid = 1'b0;
                @(negedge clk);
            end
        end
        s_arvalid = 1'b0;
        wait_drained();
        rready_random = 1'b0;
        repeat (4) @(negedge clk);

        if (ar_q.size() != 0) begin
            protocol_count++;
            $display("%0d predicted misses never requested memory", ar_q.size());
        end
        if (hit_q.size() != 0) begin
            protocol_count++;
            $display("%0d lookups never pulsed a status output", hit_q.size());
        end

        report_counts();
        if (mismatch_count + protocol_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        protocol_count++;
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        report_counts();
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== test/tex_mem_model.sv ====
`timescale 1ns/1ps

module tex_mem_model (
    input  logic                                  clk,
    input  logic                                  reset,

    input  logic [tex_cache_pkg::addr_width-1:0]  araddrx,
    input  logic [tex_cache_pkg::addr_width-1:0]  araddry,
    input  logic                                  arvalid,
    output logic                                  arready,

    output logic [tex_cache_pkg::pixel_width-1:0] rdata,
    output logic                                  rlast,
    output logic                                  rvalid,
    input  logic                                  rready
);
    import tex_cache_pkg::*;

    // stored texture, pixel (x, y)
    function automatic logic [pixel_width-1:0] texel(input int x, input int y);
        return pixel_width'(x + 16 * y + y);
    endfunction

    initial begin
        int                    delay;
        logic [addr_width-1:0] org_x;
        logic [addr_width-1:0] org_y;

        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        forever begin
            @(negedge clk);
            if (!reset && arvalid) begin
                delay = $urandom_range(3, 0);
                repeat (delay) @(negedge clk);
                org_x   = araddrx;
                org_y   = araddry;
                arready = 1'b1;
                @(negedge clk);
                arready = 1'b0;
                // one block, row-major with x fastest
                for (int beat = 0; beat < beats_per_block; beat++) begin
                    while (!rready) @(negedge clk);
                    rdata  = texel(org_x + beat % 4, org_y + beat / 4);
                    rlast  = (beat == beats_per_block - 1);
                    rvalid = 1'b1;
                    @(negedge clk);
                end
                rvalid = 1'b0;
                rlast  = 1'b0;
            end
        end
    end

endmodule

// ==== design/tex_cache_top.sv ====
`timescale 1ns/1ps

module tex_cache_top (
    input  logic                                  clk,
    input  logic                                  reset,

    input  logic                                  clear_start,
    output logic                                  clear_busy,

    input  tex_cache_pkg::tex_req_t               s_ar,
    input  logic                                  s_arvalid,
    output logic                                  s_arready,

    output logic [tex_cache_pkg::pixel_width-1:0] s_rdata,
    output logic                                  s_rvalid,
    input  logic                                  s_rready,

    output logic [tex_cache_pkg::addr_width-1:0]  m_araddrx,
    output logic [tex_cache_pkg::addr_width-1:0]  m_araddry,
    output logic                                  m_arvalid,
    input  logic                                  m_arready,

    input  logic [tex_cache_pkg::pixel_width-1:0] m_rdata,
    input  logic                                  m_rlast,
    input  logic                                  m_rvalid,
    output logic                                  m_rready,

    output logic                                  status_hit,
    output logic                                  status_miss,
    output logic                                  status_access
);
    import tex_cache_pkg::*;

    tex_dec_t    dec;
    logic        dec_valid;
    logic        dec_ready;
    tex_lookup_t lookup;
    logic        lookup_valid;
    logic        lookup_ready;
    mem_wr_t     wr;
    logic        wr_en;
    mem_rd_t     rd;
    logic        rd_valid;
    logic        rd_ready;

    // ------------------------------------------------------------------------
    // decode, tag lookup, miss fill, cache memory
    // ------------------------------------------------------------------------
    tex_addr_decode i_addr_decode (
        .clk       (clk),
        .reset     (reset),
        .req       (s_ar),
        .req_valid (s_arvalid),
        .req_ready (s_arready),
        .dec       (dec),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready)
    );

    tex_tag_table i_tag_table (
        .clk          (clk),
        .reset        (reset),
        .clear_start  (clear_start),
        .clear_busy   (clear_busy),
        .dec          (dec),
        .dec_valid    (dec_valid),
        .dec_ready    (dec_ready),
        .lookup       (lookup),
        .lookup_valid (lookup_valid),
        .lookup_ready (lookup_ready)
    );

    tex_miss_fill i_miss_fill (
        .clk           (clk),
        .reset         (reset),
        .lookup        (lookup),
        .lookup_valid  (lookup_valid),
        .lookup_ready  (lookup_ready),
        .m_araddrx     (m_araddrx),
        .m_araddry     (m_araddry),
        .m_arvalid     (m_arvalid),
        .m_arready     (m_arready),
        .m_rdata       (m_rdata),
        .m_rlast       (m_rlast),
        .m_rvalid      (m_rvalid),
        .m_rready      (m_rready),
        .wr            (wr),
        .wr_en         (wr_en),
        .rd            (rd),
        .rd_valid      (rd_valid),
        .rd_ready      (rd_ready),
        .status_hit    (status_hit),
        .status_miss   (status_miss),
        .status_access (status_access)
    );

    tex_cache_mem i_cache_mem (
        .clk         (clk),
        .reset       (reset),
        .wr          (wr),
        .wr_en       (wr_en),
        .rd          (rd),
        .rd_valid    (rd_valid),
        .rd_ready    (rd_ready),
        .pixel       (s_rdata),
        .pixel_valid (s_rvalid),
        .pixel_ready (s_rready)
    );

endmodule

// ==== design/tex_cache_mem.sv ====
`timescale 1ns/1ps

module tex_cache_mem (
    input  logic                                  clk,
    input  logic                                  reset,

    input  tex_cache_pkg::mem_wr_t                wr,
    input  logic                                  wr_en,

    input  tex_cache_pkg::mem_rd_t                rd,
    input  logic                                  rd_valid,
    output logic                                  rd_ready,

    output logic [tex_cache_pkg::pixel_width-1:0] pixel,
    output logic                                  pixel_valid,
    input  logic                                  pixel_ready
);
    import tex_cache_pkg::*;

    localparam int mem_depth = table_size * beats_per_block;

    logic [pixel_width-1:0]                  pix_mem [mem_depth];
    logic [index_width+pix_offset_width-1:0] wr_addr;
    logic [index_width+pix_offset_width-1:0] rd_addr;

    // one block per table entry
    assign wr_addr = {wr.index, wr.offset};
    assign rd_addr = {rd.index, rd.offset};

    // ------------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            pix_mem[wr_addr] <= wr.pixel;
        end
    end

    // ------------------------------------------------------------------------
    // read register
    // ------------------------------------------------------------------------
    assign rd_ready = !pixel_valid || pixel_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_valid <= 1'b0;
        end else if (rd_ready) begin
            pixel_valid <= rd_valid;
        end
    end

    // holds while the requester stalls
    always_ff @(posedge clk) begin
        if (rd_valid && rd_ready) begin
            pixel <= pix_mem[rd_addr];
        end
    end

endmodule

// ==== design/tex_miss_fill.sv ====
`timescale 1ns/1ps

module tex_miss_fill (
    input  logic                                  clk,
    input  logic                                  reset,

    input  tex_cache_pkg::tex_lookup_t            lookup,
    input  logic                                  lookup_valid,
    output logic                                  lookup_ready,

    output logic [tex_cache_pkg::addr_width-1:0]  m_araddrx,
    output logic [tex_cache_pkg::addr_width-1:0]  m_araddry,
    output logic                                  m_arvalid,
    input  logic                                  m_arready,

    input  logic [tex_cache_pkg::pixel_width-1:0] m_rdata,
    input  logic                                  m_rlast,
    input  logic                                  m_rvalid,
    output logic                                  m_rready,

    output tex_cache_pkg::mem_wr_t                wr,
    output logic                                  wr_en,
    output tex_cache_pkg::mem_rd_t                rd,
    output logic                                  rd_valid,
    input  logic                                  rd_ready,

    output logic                                  status_hit,
    output logic                                  status_miss,
    output logic                                  status_access
);
    import tex_cache_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_fill,
        st_read
    } fill_state_t;

    fill_state_t                 state;
    tex_dec_t                    miss_req;
    logic [pix_offset_width-1:0] fill_cnt;
    logic [blk_addr_width-1:0]   blk_x;
    logic [blk_addr_width-1:0]   blk_y;
    logic                        accept;

    assign lookup_ready = (state == st_idle) && rd_ready;
    assign accept       = lookup_valid && lookup_ready;

    // ------------------------------------------------------------------------
    // fill FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            fill_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept && !lookup.hit) begin
                        state <= st_request;
                    end
                end
                st_request: begin
                    if (m_arready) begin
                        state    <= st_fill;
                        fill_cnt <= '0;
                    end
                end
                st_fill: begin
                    if (m_rvalid) begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (m_rlast) begin
                            state <= st_read;
                        end
                    end
                end
                st_read: begin
                    if (rd_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // held for the whole miss
    always_ff @(posedge clk) begin
        if (accept && !lookup.hit) begin
            miss_req <= lookup.dec;
        end
    end

    // block origin from tag and index
    assign blk_x     = {miss_req.tag[tag_width/2-1:0], miss_req.index[index_width/2-1:0]};
    assign blk_y     = {miss_req.tag[tag_width-1:tag_width/2],
                        miss_req.index[index_width-1:index_width/2]};
    assign m_araddrx = {blk_x, {blk_size{1'b0}}};
    assign m_araddry = {blk_y, {blk_size{1'b0}}};
    assign m_arvalid = (state == st_request);
    assign m_rready  = (state == st_fill);

    // fill write stream
    assign wr_en     = (state == st_fill) && m_rvalid;
    assign wr.index  = miss_req.index;
    assign wr.offset = fill_cnt;
    assign wr.pixel  = m_rdata;

    // hits go straight through, a miss reads once filled
    always_comb begin
        if (state == st_read) begin
            rd.index  = miss_req.index;
            rd.offset = miss_req.offset;
            rd_valid  = 1'b1;
        end else begin
            rd.index  = lookup.dec.index;
            rd.offset = lookup.dec.offset;
            rd_valid  = (state == st_idle) && lookup_valid && lookup.hit;
        end
    end

    assign status_hit    = accept && lookup.hit;
    assign status_miss   = accept && !lookup.hit;
    assign status_access = (state != st_idle);

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    rdata_only_in_fill: assert property (
        @(posedge clk) disable iff (reset)
        m_rvalid |-> (state == st_fill)
    );

    last_on_sixteenth_beat: assert property (
        @(posedge clk) disable iff (reset)
        (m_rvalid && m_rready) |->
            (m_rlast == (fill_cnt == pix_offset_width'(beats_per_block - 1)))
    );

endmodule

// ==== design/tex_tag_table.sv ====
`timescale 1ns/1ps

module tex_tag_table (
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       clear_start,
    output logic                       clear_busy,

    input  tex_cache_pkg::tex_dec_t    dec,
    input  logic                       dec_valid,
    output logic                       dec_ready,

    output tex_cache_pkg::tex_lookup_t lookup,
    output logic                       lookup_valid,
    input  logic                       lookup_ready
);
    import tex_cache_pkg::*;

    logic [tag_width-1:0]   tag_mem [table_size];
    logic [table_size-1:0]  tag_valid;
    logic [index_width-1:0] clear_cnt;
    logic                   hit_now;
    logic                   accept;

    assign hit_now   = tag_valid[dec.index] && (tag_mem[dec.index] == dec.tag);
    assign dec_ready = !clear_busy && (!lookup_valid || lookup_ready);
    assign accept    = dec_valid && dec_ready;

    // ------------------------------------------------------------------------
    // valid bits, clear walk and output valid
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            tag_valid    <= '0;
            clear_busy   <= 1'b0;
            clear_cnt    <= '0;
            lookup_valid <= 1'b0;
        end else begin
            if (!lookup_valid || lookup_ready) begin
                lookup_valid <= accept;
            end

            // a miss allocates its entry right away
            if (accept && !hit_now) begin
                tag_valid[dec.index] <= 1'b1;
            end

            if (clear_busy) begin
                tag_valid[clear_cnt] <= 1'b0;
                clear_cnt            <= clear_cnt + 1'b1;
                if (clear_cnt == index_width'(table_size - 1)) begin
                    clear_busy <= 1'b0;
                end
            end else if (clear_start) begin
                clear_busy <= 1'b1;
                clear_cnt  <= '0;
            end
        end
    end

    // tag storage and lookup result
    always_ff @(posedge clk) begin
        if (accept) begin
            if (!hit_now) begin
                tag_mem[dec.index] <= dec.tag;
            end
            lookup.dec <= dec;
            lookup.hit <= hit_now;
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    // no allocation survives the walk
    table_empty_after_clear: assert property (
        @(posedge clk) disable iff (reset)
        $fell(clear_busy) |-> (tag_valid == '0)
    );

    // the walk covers every entry once
    clear_walk_length: assert property (
        @(posedge clk) disable iff (reset)
        (clear_start && !clear_busy) |=> clear_busy [*table_size] ##1 !clear_busy
    );

endmodule

// ==== design/tex_addr_decode.sv ====
`timescale 1ns/1ps

module tex_addr_decode (
    input  logic                    clk,
    input  logic                    reset,

    input  tex_cache_pkg::tex_req_t req,
    input  logic                    req_valid,
    output logic                    req_ready,

    output tex_cache_pkg::tex_dec_t dec,
    output logic                    dec_valid,
    input  logic                    dec_ready
);
    import tex_cache_pkg::*;

    logic [blk_addr_width-1:0] blk_x;
    logic [blk_addr_width-1:0] blk_y;
    tex_dec_t                  split;

    // block coordinates
    assign blk_x = req.x[addr_width-1:blk_size];
    assign blk_y = req.y[addr_width-1:blk_size];

    // low block bits pick the table entry, the rest is the tag
    assign split.index  = {blk_y[index_width/2-1:0], blk_x[index_width/2-1:0]};
    assign split.tag    = {blk_y[blk_addr_width-1:index_width/2],
                           blk_x[blk_addr_width-1:index_width/2]};
    // row-major, x fastest
    assign split.offset = {req.y[blk_size-1:0], req.x[blk_size-1:0]};

    // load when empty or being emptied
    assign req_ready = !dec_valid || dec_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (req_ready) begin
            dec_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            dec <= split;
        end
    end

endmodule

// ==== design/tex_cache_pkg.sv ====
package tex_cache_pkg;

    // ------------------------------------------------------------------------
    // geometry of the texture and the cache
    // ------------------------------------------------------------------------
    localparam int addr_width       = 8;
    localparam int blk_size         = 2;
    localparam int blk_addr_width   = addr_width - blk_size;
    localparam int index_width      = 4;
    localparam int tag_width        = 2 * blk_addr_width - index_width;
    localparam int table_size       = 1 << index_width;
    localparam int pix_offset_width = 2 * blk_size;
    localparam int beats_per_block  = 1 << pix_offset_width;
    localparam int pixel_width      = 8;

    // ------------------------------------------------------------------------
    // pipeline payloads
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [addr_width-1:0] x;
        logic [addr_width-1:0] y;
    } tex_req_t;

    // index and tag both hold y bits above x bits
    typedef struct packed {
        logic [index_width-1:0]      index;
        logic [tag_width-1:0]        tag;
        logic [pix_offset_width-1:0] offset;
    } tex_dec_t;

    typedef struct packed {
        tex_dec_t dec;
        logic     hit;
    } tex_lookup_t;

    typedef struct packed {
        logic [index_width-1:0]      index;
        logic [pix_offset_width-1:0] offset;
        logic [pixel_width-1:0]      pixel;
    } mem_wr_t;

    typedef struct packed {
        logic [index_width-1:0]      index;
        logic [pix_offset_width-1:0] offset;
    } mem_rd_t;

endpackage
